/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_vxu_seq \
  -f vxu_seq.f \
  -o tb_vxu_seq

./obj_dir/tb_vxu_seq

/* seq_issue_ctrl.sv */
`timescale 1ns/1ps

module seq_issue_ctrl
#(
  parameter int num_banks = vxu_seq_pkg::max_banks
)
(
  input  logic                  clk,
  input  logic                  reset,
  input  vxu_seq_pkg::fire_op_e fire_op,
  input  vxu_seq_pkg::bptr_t    ptr,
  input  vxu_seq_pkg::bptr_t    ins_ptr1,
  input  vxu_seq_pkg::bptr_t    ins_ptr2,
  input  vxu_seq_pkg::slot_t    cur_slot,
  input  vxu_seq_pkg::bptr_t    cur_cnt,
  input  vxu_seq_pkg::q_vec_t   qstall,
  output vxu_seq_pkg::seq_op_t  seq,
  output vxu_seq_pkg::q_vec_t   seq_stall,
  output logic                  advance
);

  import vxu_seq_pkg::*;

  localparam q_vec_t q_vldq  = '{vldq: 1'b1, default: 1'b0};
  localparam q_vec_t q_vsdq  = '{vsdq: 1'b1, default: 1'b0};
  localparam q_vec_t q_utaq  = '{utaq: 1'b1, default: 1'b0};
  localparam q_vec_t q_utldq = '{utldq: 1'b1, default: 1'b0};

  q_vec_t dep [num_banks];       // Slot was fired after the latest user of q.
  q_vec_t dep_next [num_banks];
  q_vec_t stall_q;               // Last seen stall of each queue.
  q_vec_t cur_use;
  logic   stall;
  logic   go;

  always_comb
  begin
    q_vec_t clr;
    case (fire_op)
      op_vlu:
      begin
        clr = q_vldq;
      end
      op_vsu:
      begin
        clr = q_vsdq;
      end
      op_vglu:
      begin
        clr = q_utaq | q_utldq;
      end
      default:
      begin
        clr = '0;
      end
    endcase

    for (int i = 0; i < num_banks; i++)
    begin
      dep_next[i] = dep[i] & ~clr;
    end

    case (fire_op)
      op_viu, op_vau0:
      begin
        dep_next[ins_ptr1] = '1;
      end
      op_vlu, op_vsu:
      begin
        dep_next[ins_ptr1] = ~clr;
      end
      op_vglu:
      begin
        dep_next[ins_ptr1] = ~q_utaq;
        dep_next[ins_ptr2] = ~q_utldq;
      end
      default:
      begin
      end
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      for (int i = 0; i < num_banks; i++)
      begin
        dep[i] <= '0;
      end
    end
    else
    begin
      dep <= dep_next;
    end
  end

  assign cur_use = cur_slot.val ? cur_slot.q : '0;

  // A flag follows qstall only while its queue owns the current slot.
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      stall_q <= '0;
    end
    else
    begin
      stall_q <= (cur_use & qstall) | (~cur_use & stall_q);
    end
  end

  assign stall = (|(cur_use & qstall)) | (|(dep[ptr] & stall_q));
  assign go    = cur_slot.val & ~stall;

  assign advance   = go;
  assign seq_stall = stall_q;

  always_comb
  begin
    seq.last    = go & cur_slot.last;
    seq.viu     = go & cur_slot.viu;
    seq.vau0    = go & cur_slot.vau0;
    seq.q       = go ? cur_slot.q : '0;
    seq.fn      = cur_slot.fn;
    seq.cnt     = cur_cnt;
    seq.vs_zero = cur_slot.vs_zero;
    seq.vt_zero = cur_slot.vt_zero;
    seq.vs      = cur_slot.vs;
    seq.vt      = cur_slot.vt;
    seq.vd      = cur_slot.vd;
    seq.imm     = cur_slot.imm;
  end

endmodule

/* seq_slot_ring.sv */
`timescale 1ns/1ps

module seq_slot_ring
#(
  parameter int num_banks = vxu_seq_pkg::max_banks
)
(
  input  logic               clk,
  input  logic               reset,
  input  vxu_seq_pkg::bcnt_t bcnt,
  input  vxu_seq_pkg::vlen_t vlen,
  input  vxu_seq_pkg::reg_t  stride,
  input  vxu_seq_pkg::fire_t fire,
  input  logic               advance,
  output vxu_seq_pkg::slot_t cur_slot,
  output vxu_seq_pkg::bptr_t cur_cnt,
  output vxu_seq_pkg::bptr_t ptr,
  output vxu_seq_pkg::bptr_t ins_ptr1,
  output vxu_seq_pkg::bptr_t ins_ptr2
);

  import vxu_seq_pkg::*;

  slot_t slots [num_banks];
  slot_t slots_next [num_banks];

  slot_t ins_a;        // Slot written at ins_ptr1.
  slot_t ins_b;        // Second half of a gather load.
  bptr_t next_ptr;
  bcnt_t bcntm1;
  logic  fire_last;

  // Pointer sum reduced modulo bcnt, sum is below 2*bcnt+1.
  function automatic bptr_t wrap_ptr(logic [3:0] sum, bcnt_t n);
    logic [3:0] s;
    s = sum;
    if (s >= n)
    begin
      s = s - n;
    end
    if (s >= n)
    begin
      s = s - n;
    end
    return s[2:0];
  endfunction

  assign next_ptr = wrap_ptr({1'b0, ptr} + 4'd1, bcnt);
  assign ins_ptr1 = next_ptr;
  assign ins_ptr2 = wrap_ptr({1'b0, ptr} + 4'd2, bcnt);

  // The pointer rotates regardless of stalls.
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      ptr <= '0;
    end
    else
    begin
      ptr <= next_ptr;
    end
  end

  assign cur_slot = slots[ptr];
  assign bcntm1   = bcnt - 4'd1;

  always_comb
  begin
    if (cur_slot.vlen < {7'd0, bcntm1})
    begin
      cur_cnt = cur_slot.vlen[2:0];
    end
    else
    begin
      cur_cnt = bcntm1[2:0];
    end
  end

  assign fire_last = vlen < {7'd0, bcnt};

  // Build the slots for the op being fired.
  always_comb
  begin
    ins_a         = '0;
    ins_a.val     = 1'b1;
    ins_a.last    = fire_last;
    ins_a.fn      = fire.fn;
    ins_a.vlen    = vlen;
    ins_a.stride  = stride;
    ins_a.vs_zero = fire.vs_zero;
    ins_a.vt_zero = fire.vt_zero;
    ins_a.vs      = {2'b00, fire.vs};
    ins_a.vt      = {2'b00, fire.vt};
    ins_a.vd      = {2'b00, fire.vd};
    ins_a.imm     = fire.imm;

    ins_b         = ins_a;
    ins_b.q.utldq = 1'b1;      // Data return half, carries vd.

    case (fire.op)
      op_viu:
      begin
        ins_a.viu = 1'b1;
      end
      op_vau0:
      begin
        ins_a.vau0 = 1'b1;
      end
      op_vlu:
      begin
        ins_a.q.vldq = 1'b1;
      end
      op_vsu:
      begin
        ins_a.q.vsdq = 1'b1;
      end
      op_vglu:
      begin
        ins_a.q.utaq = 1'b1;   // Address half, carries vs.
      end
      default:
      begin
        ins_a.val = 1'b0;
      end
    endcase
  end

  always_comb
  begin
    slot_t adv;
    adv = slots[ptr];
    slots_next = slots;

    if (advance)
    begin
      adv.vlen = adv.vlen - {7'd0, bcnt};
      adv.vs   = adv.vs + {2'b00, adv.stride};
      adv.vt   = adv.vt + {2'b00, adv.stride};
      adv.vd   = adv.vd + {2'b00, adv.stride};
      if (slots[ptr].last)
      begin
        adv.val  = 1'b0;     // Final strip went out.
        adv.last = 1'b0;
        adv.viu  = 1'b0;
        adv.vau0 = 1'b0;
        adv.q    = '0;
      end
      else if (adv.vlen < {7'd0, bcnt})
      begin
        adv.last = 1'b1;
      end
      slots_next[ptr] = adv;
    end

    // Insertion lands after the pointer, never on the advancing slot.
    if (fire.op != op_none)
    begin
      slots_next[ins_ptr1] = ins_a;
    end
    if (fire.op == op_vglu)
    begin
      slots_next[ins_ptr2] = ins_b;
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      for (int i = 0; i < num_banks; i++)
      begin
        slots[i].val  <= 1'b0;
        slots[i].last <= 1'b0;
        slots[i].viu  <= 1'b0;
        slots[i].vau0 <= 1'b0;
        slots[i].q    <= '0;
      end
    end
    else
    begin
      slots <= slots_next;
    end
  end

endmodule

/* tb_vxu_seq_tests.svh */
`ifndef TB_VXU_SEQ_TESTS_SVH
`define TB_VXU_SEQ_TESTS_SVH

// Expected strip k of an op. The half flag picks the utldq half of a gather load.
function automatic seq_op_t expect_strip(input fire_op_e op, input logic half, input fire_t f,
                                         input int len, input int strd, input int b,
                                         input int k);
  seq_op_t e;
  int      rem;
  int      n;
  e   = '0;
  rem = len - k * b;
  n   = len / b + 1;
  e.last = (k == n - 1);
  case (op)
    op_viu:  e.viu = 1'b1;
    op_vau0: e.vau0 = 1'b1;
    op_vlu:  e.q.vldq = 1'b1;
    op_vsu:  e.q.vsdq = 1'b1;
    default:
    begin
      if (half)
        e.q.utldq = 1'b1;
      else
        e.q.utaq = 1'b1;
    end
  endcase
  e.fn      = f.fn;
  e.cnt     = bptr_t'((rem < b - 1) ? rem : b - 1);
  e.vs_zero = f.vs_zero;
  e.vt_zero = f.vt_zero;
  e.vs      = breg_t'(int'(f.vs) + k * strd);   // Wraps at 128 like the banked specifier.
  e.vt      = breg_t'(int'(f.vt) + k * strd);
  e.vd      = breg_t'(int'(f.vd) + k * strd);
  e.imm     = f.imm;
  return e;
endfunction

function automatic fire_t random_fire(input fire_op_e op);
  fire_t       f;
  logic [31:0] r;
  r         = rand32();
  f         = '0;
  f.op      = op;
  f.fn      = fn_u'(r[7:0]);
  f.vs      = r[12:8];
  f.vt      = r[17:13];
  f.vd      = r[22:18];
  f.vs_zero = r[23];
  f.vt_zero = r[24];
  f.imm     = {rand32(), rand32()};
  return f;
endfunction

task automatic set_banks(input int b);
  @(posedge clk);
  bcnt <= bcnt_t'(b);
  repeat (max_banks) @(posedge clk);   // Let the pointer settle inside the new ring.
endtask

// Fire one op and check every visit until one ring turn after the final strip.
task automatic run_op(input fire_op_e op, input int b);
  fire_t   f;
  seq_op_t e;
  int      len;
  int      strd;
  int      n;
  int      halves;
  int      off;
  logic    hit;
  set_banks(b);
  f      = random_fire(op);
  len    = int'(rand32() & 32'd31);
  strd   = int'(rand32() & 32'd31);
  n      = len / b + 1;
  halves = (op == op_vglu) ? 2 : 1;
  fire   <= f;
  vlen   <= vlen_t'(len);
  stride <= reg_t'(strd);
  @(posedge clk);
  fire.op <= op_none;
  for (int t = 1; t <= (n - 1) * b + b + 2; t++)
  begin
    @(negedge clk);
    hit = 1'b0;
    for (int h = 0; h < halves; h++)
    begin
      off = t - 1 - h;   // The utldq half trails by one cycle.
      if (off >= 0 && off % b == 0 && off / b < n)
      begin
        hit = 1'b1;
        e   = expect_strip(op, h[0], f, len, strd, b, off / b);
        if (op == op_viu)
          assert (seq.fn.viu == f.fn.viu)
          else fail_check($sformatf("viu fn got %h, expected %h", seq.fn.viu, f.fn.viu));
        if (op == op_vau0)
          assert (seq.fn.vau0 == f.fn.vau0)
          else fail_check($sformatf("vau0 fn got %h, expected %h", seq.fn.vau0, f.fn.vau0));
        assert (seq == e)
        else fail_check($sformatf("%s strip %0d half %0d: got %h, expected %h",
                                  op.name(), off / b, h, seq, e));
      end
    end
    if (!hit)
      assert (strobes(seq) == 7'd0)
      else fail_check($sformatf("%s: unexpected issue at cycle %0d", op.name(), t));
  end
endtask

task automatic test_reset_idle();
  @(negedge clk);
  assert (strobes(seq) == 7'd0)
  else fail_check($sformatf("strobes after reset are %b", strobes(seq)));
  assert (seq_stall == '0)
  else fail_check($sformatf("seq_stall after reset is %b", seq_stall));
endtask

task automatic test_arith();
  for (int i = 0; i < 2; i++)
  begin
    run_op(op_viu, 8);
    run_op(op_vau0, 8);
    run_op(op_viu, 3);
    run_op(op_vau0, 3);
  end
endtask

task automatic test_load_store();
  run_op(op_vlu, 8);
  run_op(op_vsu, 8);
  run_op(op_vlu, 3);
  run_op(op_vsu, 3);
endtask

task automatic test_gather();
  run_op(op_vglu, 4);
  run_op(op_vglu, 4);
endtask

// A held vldq stall also blocks a viu fired behind the load.
task automatic test_stall_order();
  fire_t   fl;
  fire_t   fv;
  seq_op_t e;
  int      len_l;
  int      len_v;
  int      strd;
  int      kl;
  int      kv;
  int      waited;
  set_banks(4);
  fl     = random_fire(op_vlu);
  fv     = random_fire(op_viu);
  len_l  = int'(rand32() & 32'd15);
  len_v  = int'(rand32() & 32'd15);
  strd   = int'(rand32() & 32'd31);
  qstall <= '{vldq: 1'b1, default: 1'b0};
  fire   <= fl;
  vlen   <= vlen_t'(len_l);
  stride <= reg_t'(strd);
  @(posedge clk);
  fire <= fv;
  vlen <= vlen_t'(len_v);
  @(posedge clk);
  fire.op <= op_none;
  repeat (12)
  begin
    @(negedge clk);
    assert (strobes(seq) == 7'd0)
    else fail_check($sformatf("issue during vldq stall, strobes %b", strobes(seq)));
    assert (seq_stall.vldq == 1'b1)
    else fail_check("seq_stall.vldq is low while the stall is held");
  end
  @(posedge clk);
  qstall <= '0;
  kl     = 0;
  kv     = 0;
  waited = 0;
  while (kl < len_l / 4 + 1 || kv < len_v / 4 + 1)
  begin
    @(negedge clk);
    waited++;
    if (seq.q.vldq)
    begin
      e = expect_strip(op_vlu, 1'b0, fl, len_l, strd, 4, kl);
      assert (seq == e)
      else fail_check($sformatf("vlu strip %0d: got %h, expected %h", kl, seq, e));
      kl++;
    end
    else if (seq.viu)
    begin
      assert (kl > 0)
      else fail_check("viu issued before the stalled vlu");
      e = expect_strip(op_viu, 1'b0, fv, len_v, strd, 4, kv);
      assert (seq == e)
      else fail_check($sformatf("viu strip %0d: got %h, expected %h", kv, seq, e));
      kv++;
    end
    else
      assert (strobes(seq) == 7'd0)
      else fail_check($sformatf("unexpected strobes %b after release", strobes(seq)));
    assert (waited <= 200)
    else fail_check("Not all strips were delivered after the stall was released");
  end
endtask

`endif

/* tb_vxu_seq.sv */
`timescale 1ns/1ps

module tb_vxu_seq;

  import vxu_seq_pkg::*;

  localparam int timeout_cycles = 3000;   // Longest test sequence is well under a third of this.

  logic    clk;
  logic    reset;
  bcnt_t   bcnt;
  vlen_t   vlen;
  reg_t    stride;
  fire_t   fire;
  q_vec_t  qstall;
  seq_op_t seq;
  q_vec_t  seq_stall;

  integer seed;
  int     cycle_count = 0;

  vxu_seq #(.num_banks(max_banks)) i_vxu_seq (
    .clk       (clk),
    .reset     (reset),
    .bcnt      (bcnt),
    .vlen      (vlen),
    .stride    (stride),
    .fire      (fire),
    .qstall    (qstall),
    .seq       (seq),
    .seq_stall (seq_stall)
  );

  always #20 clk = ~clk;

  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles)
    begin
      $display("Timeout: the run did not finish within %0d cycles.", timeout_cycles);
      $display("SOME TESTS FAILED");
      $fatal(1, "Simulation timeout");
    end
  end

  task automatic fail_check(input string msg);
    $display("[ERROR] %0t: %s", $time, msg);
    $display("SOME TESTS FAILED");
    $fatal(1, "Check failed");
  endtask

  function automatic logic [31:0] rand32();
    logic [31:0] r;
    r = $random(seed);
    return r;
  endfunction

  // Unit and queue strobes plus last, all zero when nothing issues.
  function automatic logic [6:0] strobes(input seq_op_t s);
    return {s.last, s.viu, s.vau0, s.q};
  endfunction

  `include "tb_vxu_seq_tests.svh"

  initial
  begin
    clk    = 1'b0;
    reset  = 1'b1;
    bcnt   = 4'd8;
    vlen   = '0;
    stride = '0;
    fire   = '0;
    qstall = '0;
    seed   = 32'h5a9d;

    repeat (10) @(posedge clk);
    reset <= 1'b0;

    test_reset_idle();
    test_arith();
    test_load_store();
    test_gather();
    test_stall_order();

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

/* vxu_seq.f */
+incdir+.
vxu_seq_pkg.sv
seq_slot_ring.sv
seq_issue_ctrl.sv
vxu_seq.sv
tb_vxu_seq.sv

/* vxu_seq.sv */
`timescale 1ns/1ps

module vxu_seq
#(
  parameter int num_banks = vxu_seq_pkg::max_banks
)
(
  input  logic                 clk,
  input  logic                 reset,
  input  vxu_seq_pkg::bcnt_t   bcnt,
  input  vxu_seq_pkg::vlen_t   vlen,
  input  vxu_seq_pkg::reg_t    stride,
  input  vxu_seq_pkg::fire_t   fire,
  input  vxu_seq_pkg::q_vec_t  qstall,
  output vxu_seq_pkg::seq_op_t seq,
  output vxu_seq_pkg::q_vec_t  seq_stall
);

  import vxu_seq_pkg::*;

  slot_t cur_slot;
  bptr_t cur_cnt;
  bptr_t ptr;
  bptr_t ins_ptr1;
  bptr_t ins_ptr2;
  logic  advance;      // Current slot issued a strip.

  seq_slot_ring #(.num_banks(num_banks)) i_seq_slot_ring (
    .clk      (clk),
    .reset    (reset),
    .bcnt     (bcnt),
    .vlen     (vlen),
    .stride   (stride),
    .fire     (fire),
    .advance  (advance),
    .cur_slot (cur_slot),
    .cur_cnt  (cur_cnt),
    .ptr      (ptr),
    .ins_ptr1 (ins_ptr1),
    .ins_ptr2 (ins_ptr2)
  );

  seq_issue_ctrl #(.num_banks(num_banks)) i_seq_issue_ctrl (
    .clk       (clk),
    .reset     (reset),
    .fire_op   (fire.op),
    .ptr       (ptr),
    .ins_ptr1  (ins_ptr1),
    .ins_ptr2  (ins_ptr2),
    .cur_slot  (cur_slot),
    .cur_cnt   (cur_cnt),
    .qstall    (qstall),
    .seq       (seq),
    .seq_stall (seq_stall),
    .advance   (advance)
  );

endmodule

/* vxu_seq_pkg.sv */
package vxu_seq_pkg;

  localparam int max_banks = 8;

  typedef logic [3:0]  bcnt_t;   // Active banks, 1 to 8.
  typedef logic [2:0]  bptr_t;   // Slot index.
  typedef logic [10:0] vlen_t;   // Vector length minus one.
  typedef logic [4:0]  reg_t;    // Register specifier as fired.
  typedef logic [6:0]  breg_t;   // Banked register specifier.
  typedef logic [63:0] data_t;

  typedef enum logic [2:0] {
    op_none = 3'd0,
    op_viu  = 3'd1,
    op_vau0 = 3'd2,
    op_vlu  = 3'd3,
    op_vsu  = 3'd4,
    op_vglu = 3'd5
  } fire_op_e;

  typedef logic [7:0] viu_fn_t;
  typedef logic [7:0] vau0_fn_t;

  // Read as viu or vau0 code depending on the unit flag of the slot.
  typedef union packed {
    viu_fn_t  viu;
    vau0_fn_t vau0;
  } fn_u;

  typedef struct packed {
    logic vldq;
    logic vsdq;
    logic utaq;
    logic utldq;
  } q_vec_t;

  typedef struct packed {
    fire_op_e op;
    fn_u      fn;
    reg_t     vs;
    reg_t     vt;
    reg_t     vd;
    logic     vs_zero;
    logic     vt_zero;
    data_t    imm;
  } fire_t;

  typedef struct packed {
    logic   val;
    logic   last;      // Next visit issues the final strip.
    logic   viu;
    logic   vau0;
    q_vec_t q;
    fn_u    fn;
    vlen_t  vlen;      // Remaining elements minus one.
    reg_t   stride;
    logic   vs_zero;
    logic   vt_zero;
    breg_t  vs;
    breg_t  vt;
    breg_t  vd;
    data_t  imm;
  } slot_t;

  typedef struct packed {
    logic   last;
    logic   viu;
    logic   vau0;
    q_vec_t q;
    fn_u    fn;
    bptr_t  cnt;       // Elements in this strip minus one.
    logic   vs_zero;
    logic   vt_zero;
    breg_t  vs;
    breg_t  vt;
    breg_t  vd;
    data_t  imm;
  } seq_op_t;

endpackage
